// File: xconf_settings.svh
`ifndef XCONF_SETTINGS_SVH
`define XCONF_SETTINGS_SVH

// slot counts, two ports per memory
`define N_MEM             2
`define N_MEM_PORT        (2*`N_MEM)
`define N_ALU             2
`define N_MUL             2

// field widths
`define SEL_W             5
`define MEM_ADDR_W        10
`define PERIOD_W          5
`define ALU_FNS_W         4
`define MUL_FNS_W         2

// control port
`define CTR_ADDR_W        7
`define CTR_DATA_W        32

// address map
`define CONF_CLEAR        0
`define CONF_MEM_BASE     16
`define MEM_CONF_STRIDE   16
`define CONF_ALU_BASE     80
`define CONF_MUL_BASE     96
`define FU_CONF_STRIDE    4

// memory port field indices
`define MEM_F_ITER        0
`define MEM_F_PER         1
`define MEM_F_DUTY        2
`define MEM_F_SEL         3
`define MEM_F_START       4
`define MEM_F_SHIFT       5
`define MEM_F_INCR        6
`define MEM_F_DELAY       7
`define MEM_F_RVRS        8
`define MEM_F_EXT         9
`define MEM_F_IN_WR       10
`define MEM_F_ITER2       11
`define MEM_F_PER2        12
`define MEM_F_SHIFT2      13
`define MEM_F_INCR2       14

// functional unit field indices
`define FU_F_SELA         0
`define FU_F_SELB         1
`define FU_F_FNS          2

// packed slot widths
`define MEM_CONF_BITS     (7*`MEM_ADDR_W + 4*`PERIOD_W + `SEL_W + 3)
`define ALU_CONF_BITS     (2*`SEL_W + `ALU_FNS_W)
`define MUL_CONF_BITS     (2*`SEL_W + `MUL_FNS_W)
`define CONF_BITS         (`N_MEM_PORT*`MEM_CONF_BITS + `N_ALU*`ALU_CONF_BITS + `N_MUL*`MUL_CONF_BITS)

`endif

// File: xconf_pkg.sv
`default_nettype none
`include "xconf_settings.svh"

package xconf_pkg;

   typedef logic [`SEL_W-1:0]      sel_t;

   // address generator fields
   typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
   typedef logic [`PERIOD_W-1:0]   period_t;

   typedef logic [`ALU_FNS_W-1:0]  alu_fns_t;
   typedef logic [`MUL_FNS_W-1:0]  mul_fns_t;

   typedef logic [`CTR_ADDR_W-1:0] ctr_addr_t;
   typedef logic [`CTR_DATA_W-1:0] ctr_data_t;

   typedef logic [1:0]             fu_field_t;
   typedef logic [3:0]             mem_field_t;

   // field order follows the index map, iter at the top
   typedef struct packed {
      mem_addr_t iter;
      period_t   per;
      period_t   duty;
      sel_t      sel;
      mem_addr_t start;
      mem_addr_t shift;
      mem_addr_t incr;
      period_t   delay;
      logic      rvrs;
      logic      ext;
      logic      in_wr;
      mem_addr_t iter2;
      period_t   per2;
      mem_addr_t shift2;
      mem_addr_t incr2;
   } mem_port_conf_t;

   typedef logic [`CONF_BITS-1:0]  conf_vec_t;

endpackage

`default_nettype wire

// File: conf_addr_dec.sv
`timescale 1ns/1ns
`default_nettype none
`include "xconf_settings.svh"

module conf_addr_dec (
   input  logic                    ctr_valid,
   input  logic                    ctr_we,
   input  xconf_pkg::ctr_addr_t    ctr_addr,
   output logic                    clr,
   output logic [`N_MEM_PORT-1:0]  mem_we,
   output logic [`N_ALU-1:0]       alu_we,
   output logic [`N_MUL-1:0]       mul_we,
   output xconf_pkg::mem_field_t   mem_field,
   output xconf_pkg::fu_field_t    fu_field
);

   import xconf_pkg::*;

   logic      wr;
   logic      wr_slot;
   ctr_addr_t mem_off;
   ctr_addr_t alu_off;
   ctr_addr_t mul_off;
   ctr_addr_t mem_slot;
   ctr_addr_t alu_slot;
   ctr_addr_t mul_slot;
   logic      mem_hit;
   logic      alu_hit;
   logic      mul_hit;

   assign wr      = ctr_valid & ctr_we;
   assign clr     = wr & (ctr_addr == ctr_addr_t'(`CONF_CLEAR));
   assign wr_slot = wr & ~clr;

   // offset from each kind's base
   assign mem_off = ctr_addr - ctr_addr_t'(`CONF_MEM_BASE);
   assign alu_off = ctr_addr - ctr_addr_t'(`CONF_ALU_BASE);
   assign mul_off = ctr_addr - ctr_addr_t'(`CONF_MUL_BASE);

   assign mem_slot = mem_off / ctr_addr_t'(`MEM_CONF_STRIDE);
   assign alu_slot = alu_off / ctr_addr_t'(`FU_CONF_STRIDE);
   assign mul_slot = mul_off / ctr_addr_t'(`FU_CONF_STRIDE);

   assign mem_field = mem_field_t'(mem_off % ctr_addr_t'(`MEM_CONF_STRIDE));
   // both fu bases are stride aligned so alu and mul share one field index
   assign fu_field  = fu_field_t'(alu_off % ctr_addr_t'(`FU_CONF_STRIDE));

   // in range and a field that exists
   assign mem_hit = wr_slot
                    & (ctr_addr >= ctr_addr_t'(`CONF_MEM_BASE))
                    & (mem_slot < ctr_addr_t'(`N_MEM_PORT))
                    & (mem_field <= mem_field_t'(`MEM_F_INCR2));
   assign alu_hit = wr_slot
                    & (ctr_addr >= ctr_addr_t'(`CONF_ALU_BASE))
                    & (alu_slot < ctr_addr_t'(`N_ALU))
                    & (fu_field <= fu_field_t'(`FU_F_FNS));
   assign mul_hit = wr_slot
                    & (ctr_addr >= ctr_addr_t'(`CONF_MUL_BASE))
                    & (mul_slot < ctr_addr_t'(`N_MUL))
                    & (fu_field <= fu_field_t'(`FU_F_FNS));

   always_comb begin
      for (int i = 0; i < `N_MEM_PORT; i++) begin
         mem_we[i] = mem_hit & (mem_slot == ctr_addr_t'(i));
      end
      for (int i = 0; i < `N_ALU; i++) begin
         alu_we[i] = alu_hit & (alu_slot == ctr_addr_t'(i));
      end
      for (int i = 0; i < `N_MUL; i++) begin
         mul_we[i] = mul_hit & (mul_slot == ctr_addr_t'(i));
      end
   end

endmodule

`default_nettype wire

// File: mem_port_conf.sv
`timescale 1ns/1ns
`default_nettype none
`include "xconf_settings.svh"

module mem_port_conf (
   input  logic                        rst,
   input  logic                        clk,
   input  logic                        ld,
   input  xconf_pkg::mem_port_conf_t   ld_conf,
   input  logic                        clr,
   input  logic                        we,
   input  xconf_pkg::mem_field_t       field,
   input  xconf_pkg::ctr_data_t        data,
   output xconf_pkg::mem_port_conf_t   conf
);

   import xconf_pkg::*;

   // rst is the clock and clk the async reset here
   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         conf <= '0;
      end else if (ld) begin
         conf <= ld_conf;
      end else if (clr) begin
         conf <= '0;
      end else if (we) begin
         case (field)
            `MEM_F_ITER: begin
               conf.iter <= mem_addr_t'(data);
            end
            `MEM_F_PER: begin
               conf.per <= period_t'(data);
            end
            `MEM_F_DUTY: begin
               conf.duty <= period_t'(data);
            end
            `MEM_F_SEL: begin
               conf.sel <= sel_t'(data);
            end
            `MEM_F_START: begin
               conf.start <= mem_addr_t'(data);
            end
            `MEM_F_SHIFT: begin
               conf.shift <= mem_addr_t'(data);
            end
            `MEM_F_INCR: begin
               conf.incr <= mem_addr_t'(data);
            end
            `MEM_F_DELAY: begin
               conf.delay <= period_t'(data);
            end
            `MEM_F_RVRS: begin
               conf.rvrs <= data[0];
            end
            `MEM_F_EXT: begin
               conf.ext <= data[0];
            end
            `MEM_F_IN_WR: begin
               conf.in_wr <= data[0];
            end
            // second address generator level
            `MEM_F_ITER2: begin
               conf.iter2 <= mem_addr_t'(data);
            end
            `MEM_F_PER2: begin
               conf.per2 <= period_t'(data);
            end
            `MEM_F_SHIFT2: begin
               conf.shift2 <= mem_addr_t'(data);
            end
            `MEM_F_INCR2: begin
               conf.incr2 <= mem_addr_t'(data);
            end
            default: begin
               // index 15 has no field
               conf <= conf;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: fu_conf.sv
`timescale 1ns/1ns
`default_nettype none
`include "xconf_settings.svh"

module fu_conf #(
   parameter type fns_t = xconf_pkg::alu_fns_t
) (
   input  logic                  rst,
   input  logic                  clk,
   input  logic                  ld,
   input  xconf_pkg::sel_t       ld_sela,
   input  xconf_pkg::sel_t       ld_selb,
   input  fns_t                  ld_fns,
   input  logic                  clr,
   input  logic                  we,
   input  xconf_pkg::fu_field_t  field,
   input  xconf_pkg::ctr_data_t  data,
   output xconf_pkg::sel_t       sela,
   output xconf_pkg::sel_t       selb,
   output fns_t                  fns
);

   import xconf_pkg::*;

   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         sela <= '0;
         selb <= '0;
         fns  <= '0;
      end else if (ld) begin
         sela <= ld_sela;
         selb <= ld_selb;
         fns  <= ld_fns;
      end else if (clr) begin
         sela <= '0;
         selb <= '0;
         fns  <= '0;
      end else if (we) begin
         // field 3 is a hole in the map
         case (field)
            `FU_F_SELA: sela <= sel_t'(data);
            `FU_F_SELB: selb <= sel_t'(data);
            `FU_F_FNS:  fns  <= fns_t'(data);
            default:    fns  <= fns;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: xconf_reg.sv
`timescale 1ns/1ns
`default_nettype none
`include "xconf_settings.svh"

module xconf_reg (
   input  logic                  rst,
   input  logic                  clk,
   input  logic                  ctr_valid,
   input  logic                  ctr_we,
   input  xconf_pkg::ctr_addr_t  ctr_addr,
   input  xconf_pkg::ctr_data_t  ctr_data,
   input  logic                  conf_ld,
   input  xconf_pkg::conf_vec_t  conf_in,
   output xconf_pkg::conf_vec_t  conf_out
);

   import xconf_pkg::*;

   // msb of each kind's region
   localparam int MEM_TOP = `CONF_BITS - 1;
   localparam int ALU_TOP = MEM_TOP - `N_MEM_PORT*`MEM_CONF_BITS;
   localparam int MUL_TOP = ALU_TOP - `N_ALU*`ALU_CONF_BITS;

   logic                   clr;
   logic [`N_MEM_PORT-1:0] mem_we;
   logic [`N_ALU-1:0]      alu_we;
   logic [`N_MUL-1:0]      mul_we;
   mem_field_t             mem_field;
   fu_field_t              fu_field;

   mem_port_conf_t         mem_conf [`N_MEM_PORT];
   sel_t                   alu_sela [`N_ALU];
   sel_t                   alu_selb [`N_ALU];
   alu_fns_t               alu_fns  [`N_ALU];
   sel_t                   mul_sela [`N_MUL];
   sel_t                   mul_selb [`N_MUL];
   mul_fns_t               mul_fns  [`N_MUL];

   conf_addr_dec conf_addr_dec_inst (
      .ctr_valid (ctr_valid),
      .ctr_we    (ctr_we),
      .ctr_addr  (ctr_addr),
      .clr       (clr),
      .mem_we    (mem_we),
      .alu_we    (alu_we),
      .mul_we    (mul_we),
      .mem_field (mem_field),
      .fu_field  (fu_field)
   );

   for (genvar i = 0; i < `N_MEM_PORT; i++) begin : gen_mem
      mem_port_conf mem_port_conf_inst (
         .rst     (rst),
         .clk     (clk),
         .ld      (conf_ld),
         .ld_conf (conf_in[MEM_TOP - i*`MEM_CONF_BITS -: `MEM_CONF_BITS]),
         .clr     (clr),
         .we      (mem_we[i]),
         .field   (mem_field),
         .data    (ctr_data),
         .conf    (mem_conf[i])
      );
   end

   for (genvar i = 0; i < `N_ALU; i++) begin : gen_alu
      fu_conf #(
         .fns_t (alu_fns_t)
      ) fu_conf_inst (
         .rst     (rst),
         .clk     (clk),
         .ld      (conf_ld),
         .ld_sela (conf_in[ALU_TOP - i*`ALU_CONF_BITS -: `SEL_W]),
         .ld_selb (conf_in[ALU_TOP - i*`ALU_CONF_BITS - `SEL_W -: `SEL_W]),
         .ld_fns  (conf_in[ALU_TOP - i*`ALU_CONF_BITS - 2*`SEL_W -: `ALU_FNS_W]),
         .clr     (clr),
         .we      (alu_we[i]),
         .field   (fu_field),
         .data    (ctr_data),
         .sela    (alu_sela[i]),
         .selb    (alu_selb[i]),
         .fns     (alu_fns[i])
      );
   end

   for (genvar i = 0; i < `N_MUL; i++) begin : gen_mul
      fu_conf #(
         .fns_t (mul_fns_t)
      ) fu_conf_inst (
         .rst     (rst),
         .clk     (clk),
         .ld      (conf_ld),
         .ld_sela (conf_in[MUL_TOP - i*`MUL_CONF_BITS -: `SEL_W]),
         .ld_selb (conf_in[MUL_TOP - i*`MUL_CONF_BITS - `SEL_W -: `SEL_W]),
         .ld_fns  (conf_in[MUL_TOP - i*`MUL_CONF_BITS - 2*`SEL_W -: `MUL_FNS_W]),
         .clr     (clr),
         .we      (mul_we[i]),
         .field   (fu_field),
         .data    (ctr_data),
         .sela    (mul_sela[i]),
         .selb    (mul_selb[i]),
         .fns     (mul_fns[i])
      );
   end

   // slot 0 of each kind sits at the top of its region
   always_comb begin
      for (int i = 0; i < `N_MEM_PORT; i++) begin
         conf_out[MEM_TOP - i*`MEM_CONF_BITS -: `MEM_CONF_BITS] = mem_conf[i];
      end
      for (int i = 0; i < `N_ALU; i++) begin
         conf_out[ALU_TOP - i*`ALU_CONF_BITS -: `ALU_CONF_BITS] =
            {alu_sela[i], alu_selb[i], alu_fns[i]};
      end
      for (int i = 0; i < `N_MUL; i++) begin
         conf_out[MUL_TOP - i*`MUL_CONF_BITS -: `MUL_CONF_BITS] =
            {mul_sela[i], mul_selb[i], mul_fns[i]};
      end
   end

endmodule

`default_nettype wire

// File: xconf_model.svh
`ifndef XCONF_MODEL_SVH
`define XCONF_MODEL_SVH

// shadow slots, one word per field index
logic [31:0] m_mem [`N_MEM_PORT][16];
logic [31:0] m_alu [`N_ALU][3];
logic [31:0] m_mul [`N_MUL][3];

function automatic int mem_field_w(input int f);
   case (f)
      `MEM_F_PER, `MEM_F_DUTY, `MEM_F_DELAY, `MEM_F_PER2: return `PERIOD_W;
      `MEM_F_SEL: return `SEL_W;
      `MEM_F_RVRS, `MEM_F_EXT, `MEM_F_IN_WR: return 1;
      default: return `MEM_ADDR_W;
   endcase
endfunction

function automatic int fu_field_w(input bit is_mul, input int f);
   if (f != `FU_F_FNS) begin
      return `SEL_W;
   end
   return is_mul ? `MUL_FNS_W : `ALU_FNS_W;
endfunction

function automatic logic [31:0] low_bits(input logic [31:0] val, input int w);
   if (w >= 32) begin
      return val;
   end
   return val & ((32'd1 << w) - 32'd1);
endfunction

task automatic model_clear();
   foreach (m_mem[p, f]) m_mem[p][f] = '0;
   foreach (m_alu[s, f]) m_alu[s][f] = '0;
   foreach (m_mul[s, f]) m_mul[s][f] = '0;
endtask

task automatic model_write(input int addr, input logic [31:0] data);
   int off;
   int f;
   if (addr == `CONF_CLEAR) begin
      model_clear();
   end else if (addr >= `CONF_MEM_BASE &&
                addr < `CONF_MEM_BASE + `N_MEM_PORT*`MEM_CONF_STRIDE) begin
      off = addr - `CONF_MEM_BASE;
      f = off % `MEM_CONF_STRIDE;
      // index 15 has no field
      if (f <= `MEM_F_INCR2) begin
         m_mem[off / `MEM_CONF_STRIDE][f] = low_bits(data, mem_field_w(f));
      end
   end else if (addr >= `CONF_ALU_BASE &&
                addr < `CONF_ALU_BASE + `N_ALU*`FU_CONF_STRIDE) begin
      off = addr - `CONF_ALU_BASE;
      f = off % `FU_CONF_STRIDE;
      if (f <= `FU_F_FNS) begin
         m_alu[off / `FU_CONF_STRIDE][f] = low_bits(data, fu_field_w(1'b0, f));
      end
   end else if (addr >= `CONF_MUL_BASE &&
                addr < `CONF_MUL_BASE + `N_MUL*`FU_CONF_STRIDE) begin
      off = addr - `CONF_MUL_BASE;
      f = off % `FU_CONF_STRIDE;
      if (f <= `FU_F_FNS) begin
         m_mul[off / `FU_CONF_STRIDE][f] = low_bits(data, fu_field_w(1'b1, f));
      end
   end
endtask

// memory ports first, iter field at the top, then alu and mul slots
function automatic conf_vec_t model_vec();
   conf_vec_t v;
   v = '0;
   foreach (m_mem[p, f]) begin
      if (f <= `MEM_F_INCR2) v = (v << mem_field_w(f)) | conf_vec_t'(m_mem[p][f]);
   end
   foreach (m_alu[s, f]) v = (v << fu_field_w(1'b0, f)) | conf_vec_t'(m_alu[s][f]);
   foreach (m_mul[s, f]) v = (v << fu_field_w(1'b1, f)) | conf_vec_t'(m_mul[s][f]);
   return v;
endfunction

task automatic model_load(input conf_vec_t vec);
   int pos;
   conf_vec_t tmp;
   pos = `CONF_BITS;
   foreach (m_mem[p, f]) begin
      if (f <= `MEM_F_INCR2) begin
         pos = pos - mem_field_w(f);
         tmp = vec >> pos;
         m_mem[p][f] = low_bits(tmp[31:0], mem_field_w(f));
      end
   end
   foreach (m_alu[s, f]) begin
      pos = pos - fu_field_w(1'b0, f);
      tmp = vec >> pos;
      m_alu[s][f] = low_bits(tmp[31:0], fu_field_w(1'b0, f));
   end
   foreach (m_mul[s, f]) begin
      pos = pos - fu_field_w(1'b1, f);
      tmp = vec >> pos;
      m_mul[s][f] = low_bits(tmp[31:0], fu_field_w(1'b1, f));
   end
endtask

// load wins over clear and field writes
task automatic model_step(input logic ld, input conf_vec_t vec, input logic valid,
                          input logic we, input int addr, input logic [31:0] data);
   if (ld) begin
      model_load(vec);
   end else if (valid && we) begin
      model_write(addr, data);
   end
endtask

`endif

// File: xconf_reg_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "xconf_settings.svh"

module xconf_reg_tb;

   import xconf_pkg::*;

   localparam int CLK_HALF     = 20;
   localparam int DRV_DLY      = 2;
   localparam int EDGE_TIMEOUT = 200;

   // rst is the clock and clk the async reset of this design
   logic        rst;
   logic        clk;
   logic        ctr_valid;
   logic        ctr_we;
   ctr_addr_t   ctr_addr;
   ctr_data_t   ctr_data;
   logic        conf_ld;
   conf_vec_t   conf_in;
   conf_vec_t   conf_out;

   int          seed;
   int unsigned cycle_cnt = 0;
   int          test_cnt = 0;
   int          checks = 0;
   int          errors = 0;
   int          test_checks;
   int          test_errs;
   string       test_name;

   `include "xconf_model.svh"

   xconf_reg xconf_reg_inst (
      .rst       (rst),
      .clk       (clk),
      .ctr_valid (ctr_valid),
      .ctr_we    (ctr_we),
      .ctr_addr  (ctr_addr),
      .ctr_data  (ctr_data),
      .conf_ld   (conf_ld),
      .conf_in   (conf_in),
      .conf_out  (conf_out)
   );

   initial begin
      rst = 1'b0;
      forever begin
         #CLK_HALF;
         rst = ~rst;
      end
   end

   always @(posedge rst) cycle_cnt <= cycle_cnt + 1;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Errors found");
      $finish;
   endtask

   // returns DRV_DLY after the next rising edge
   task automatic next_cycle();
      int unsigned start;
      int waited;
      start = cycle_cnt;
      waited = 0;
      while (cycle_cnt == start && waited < EDGE_TIMEOUT) begin
         #1;
         waited++;
      end
      if (cycle_cnt == start) begin
         abort_run("clock stopped, no rising edge seen");
      end else begin
         #(DRV_DLY - 1);
      end
   endtask

   function automatic int rnd(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic conf_vec_t rnd_vec();
      conf_vec_t v;
      int k;
      v = '0;
      for (k = 0; k < (`CONF_BITS + 31) / 32; k++) begin
         v = (v << 32) | conf_vec_t'($unsigned($random(seed)));
      end
      return v;
   endfunction

   function automatic int mem_rand_addr();
      int port;
      int field;
      port = rnd(`N_MEM_PORT);
      field = rnd(`MEM_CONF_STRIDE);
      return `CONF_MEM_BASE + port*`MEM_CONF_STRIDE + field;
   endfunction

   function automatic int fu_rand_addr(input bit is_mul);
      int slot;
      int field;
      slot = rnd(is_mul ? `N_MUL : `N_ALU);
      field = rnd(`FU_CONF_STRIDE);
      return (is_mul ? `CONF_MUL_BASE : `CONF_ALU_BASE) + slot*`FU_CONF_STRIDE + field;
   endfunction

   function automatic int mapped_addr();
      int kind;
      kind = rnd(3);
      if (kind == 0) begin
         return mem_rand_addr();
      end
      return fu_rand_addr(kind == 2);
   endfunction

   task automatic begin_test(input string name);
      test_name = name;
      test_checks = 0;
      test_errs = 0;
      test_cnt++;
   endtask

   task automatic end_test();
      $display("test %s done: %0d checks, %0d mismatches", test_name, test_checks, test_errs);
   endtask

   task automatic check_value(input conf_vec_t exp);
      checks++;
      test_checks++;
      if (conf_out !== exp) begin
         errors++;
         test_errs++;
         $display("[ERROR] %s: expected %h, actual %h", test_name, exp, conf_out);
      end
   endtask

   // one stimulus cycle, checked right after the edge that takes it
   task automatic drive(input logic ld, input conf_vec_t vec, input logic valid,
                        input logic we, input int addr, input logic [31:0] data);
      conf_ld   = ld;
      conf_in   = vec;
      ctr_valid = valid;
      ctr_we    = we;
      ctr_addr  = ctr_addr_t'(addr);
      ctr_data  = data;
      model_step(ld, vec, valid, we, addr, data);
      next_cycle();
      conf_ld   = 1'b0;
      ctr_valid = 1'b0;
      ctr_we    = 1'b0;
      check_value(model_vec());
   endtask

   task automatic write(input int addr, input logic [31:0] data);
      drive(1'b0, '0, 1'b1, 1'b1, addr, data);
   endtask

   initial begin
      int i;
      int r;
      conf_vec_t vec;
      seed = 32'ha452_80ea;
      clk = 1'b1;
      ctr_valid = 1'b0;
      ctr_we = 1'b0;
      ctr_addr = '0;
      ctr_data = '0;
      conf_ld = 1'b0;
      conf_in = '0;
      model_clear();
      repeat (4) next_cycle();
      clk = 1'b0;

      begin_test("reset");
      check_value('0);
      end_test();

      begin_test("mem_port_writes");
      for (i = 0; i < 200; i++) write(mem_rand_addr(), $random(seed));
      end_test();

      begin_test("fu_writes");
      for (i = 0; i < 200; i++) write(fu_rand_addr(rnd(2) == 1), $random(seed));
      end_test();

      begin_test("ignored_writes");
      for (i = 0; i < 80; i++) begin
         r = rnd(4);
         if (r == 0) begin
            write(1 + rnd(15), $random(seed));
         end else if (r == 1) begin
            write(`CONF_ALU_BASE + `N_ALU*`FU_CONF_STRIDE + rnd(8), $random(seed));
         end else if (r == 2) begin
            write(`CONF_MUL_BASE + `N_MUL*`FU_CONF_STRIDE + rnd(24), $random(seed));
         end else begin
            // valid or we low, address may even be the clear
            r = rnd(2);
            drive(1'b0, '0, r == 1, r == 0, rnd(128), $random(seed));
         end
      end
      end_test();

      begin_test("clear");
      for (i = 0; i < 40; i++) write(mapped_addr(), $random(seed));
      write(`CONF_CLEAR, $random(seed));
      check_value('0);
      end_test();

      begin_test("conf_load");
      for (i = 0; i < 30; i++) begin
         vec = rnd_vec();
         r = rnd(3);
         if (r == 0) begin
            drive(1'b1, vec, 1'b0, 1'b0, 0, '0);
         end else if (r == 1) begin
            drive(1'b1, vec, 1'b1, 1'b1, `CONF_CLEAR, $random(seed));
         end else begin
            drive(1'b1, vec, 1'b1, 1'b1, mapped_addr(), $random(seed));
         end
         check_value(vec);
         write(mapped_addr(), $random(seed));
      end
      end_test();

      $display("tests %0d, checks %0d, mismatches %0d", test_cnt, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
xconf_pkg.sv
conf_addr_dec.sv
mem_port_conf.sv
fu_conf.sv
xconf_reg.sv
xconf_reg_tb.sv

// File: run_sim.sh
#!/bin/bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timescale 1ns/1ns --top-module xconf_reg_tb -f tb.f -o xconf_sim \
   && ./obj_dir/xconf_sim | tee /dev/stderr | grep -q "No errors" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
